/* design/cpu_pkg.sv */
package cpu_pkg;

  localparam int ADDR_W = 13;  // 8 KiB of RAM
  localparam int PC_W   = 16;

  typedef logic [7:0]        byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PC_W-1:0]   pc_t;

  localparam pc_t RESET_PC = 16'h0200;

  // Supported opcodes, everything else runs as a one-byte no-op
  typedef enum logic [7:0] {
    JMP_ABS  = 8'h4C,
    LDA_IMM  = 8'hA9,
    LDA_ZP   = 8'hA5,
    LDA_ZPX  = 8'hB5,
    LDA_ABS  = 8'hAD,
    LDA_ABSX = 8'hBD,
    LDA_ABSY = 8'hB9,
    LDX_IMM  = 8'hA2,
    LDX_ZP   = 8'hA6,
    LDX_ZPY  = 8'hB6,
    LDX_ABS  = 8'hAE,
    LDX_ABSY = 8'hBE,
    LDY_IMM  = 8'hA0,
    LDY_ZP   = 8'hA4,
    LDY_ZPX  = 8'hB4,
    LDY_ABS  = 8'hAC,
    LDY_ABSX = 8'hBC
  } opcode_t;

  typedef enum logic [1:0] {
    NOP,
    LOAD,
    JUMP
  } instr_class_t;

  typedef enum logic [2:0] {
    IMM,
    ZP,
    ZP_IDX,   // Wraps inside page zero
    ABS,
    ABS_IDX
  } addr_mode_t;

  // Load destination or index register
  typedef enum logic [1:0] {
    REG_A,
    REG_X,
    REG_Y
  } reg_sel_t;

  typedef struct packed {
    instr_class_t cls;
    addr_mode_t   mode;
    reg_sel_t     dst;
    reg_sel_t     idx;
    logic [1:0]   len;   // Instruction bytes, 1 to 3
  } instr_info_t;

  typedef struct packed {
    logic     valid;
    logic     load;      // Writes dst and the flags
    reg_sel_t dst;
    byte_t    value;
    pc_t      next_pc;
  } commit_t;

  typedef struct packed {
    pc_t   pc;
    byte_t a;
    byte_t x;
    byte_t y;
    logic  n;
    logic  z;
  } arch_state_t;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
  input  cpu_pkg::byte_t       opcode,
  output cpu_pkg::instr_info_t info
);

  // One table row, length follows from the mode
  function automatic cpu_pkg::instr_info_t row(
    input cpu_pkg::instr_class_t cls,
    input cpu_pkg::addr_mode_t   mode,
    input cpu_pkg::reg_sel_t     dst,
    input cpu_pkg::reg_sel_t     idx
  );
    cpu_pkg::instr_info_t r;
    r.cls  = cls;
    r.mode = mode;
    r.dst  = dst;
    r.idx  = idx;
    if (cls == cpu_pkg::NOP) begin
      r.len = 2'd1;
    end else if (mode == cpu_pkg::ABS || mode == cpu_pkg::ABS_IDX) begin
      r.len = 2'd3;
    end else begin
      r.len = 2'd2;
    end
    return r;
  endfunction

  always_comb begin
    case (opcode)
      cpu_pkg::JMP_ABS:  info = row(cpu_pkg::JUMP, cpu_pkg::ABS, cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_IMM:  info = row(cpu_pkg::LOAD, cpu_pkg::IMM, cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_ZP:   info = row(cpu_pkg::LOAD, cpu_pkg::ZP, cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_ZPX:  info = row(cpu_pkg::LOAD, cpu_pkg::ZP_IDX,
                                    cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_ABS:  info = row(cpu_pkg::LOAD, cpu_pkg::ABS, cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_ABSX: info = row(cpu_pkg::LOAD, cpu_pkg::ABS_IDX,
                                    cpu_pkg::REG_A, cpu_pkg::REG_X);
      cpu_pkg::LDA_ABSY: info = row(cpu_pkg::LOAD, cpu_pkg::ABS_IDX,
                                    cpu_pkg::REG_A, cpu_pkg::REG_Y);
      // LDX indexes with Y
      cpu_pkg::LDX_IMM:  info = row(cpu_pkg::LOAD, cpu_pkg::IMM, cpu_pkg::REG_X, cpu_pkg::REG_Y);
      cpu_pkg::LDX_ZP:   info = row(cpu_pkg::LOAD, cpu_pkg::ZP, cpu_pkg::REG_X, cpu_pkg::REG_Y);
      cpu_pkg::LDX_ZPY:  info = row(cpu_pkg::LOAD, cpu_pkg::ZP_IDX,
                                    cpu_pkg::REG_X, cpu_pkg::REG_Y);
      cpu_pkg::LDX_ABS:  info = row(cpu_pkg::LOAD, cpu_pkg::ABS, cpu_pkg::REG_X, cpu_pkg::REG_Y);
      cpu_pkg::LDX_ABSY: info = row(cpu_pkg::LOAD, cpu_pkg::ABS_IDX,
                                    cpu_pkg::REG_X, cpu_pkg::REG_Y);
      // LDY indexes with X
      cpu_pkg::LDY_IMM:  info = row(cpu_pkg::LOAD, cpu_pkg::IMM, cpu_pkg::REG_Y, cpu_pkg::REG_X);
      cpu_pkg::LDY_ZP:   info = row(cpu_pkg::LOAD, cpu_pkg::ZP, cpu_pkg::REG_Y, cpu_pkg::REG_X);
      cpu_pkg::LDY_ZPX:  info = row(cpu_pkg::LOAD, cpu_pkg::ZP_IDX,
                                    cpu_pkg::REG_Y, cpu_pkg::REG_X);
      cpu_pkg::LDY_ABS:  info = row(cpu_pkg::LOAD, cpu_pkg::ABS, cpu_pkg::REG_Y, cpu_pkg::REG_X);
      cpu_pkg::LDY_ABSX: info = row(cpu_pkg::LOAD, cpu_pkg::ABS_IDX,
                                    cpu_pkg::REG_Y, cpu_pkg::REG_X);
      default:           info = row(cpu_pkg::NOP, cpu_pkg::IMM, cpu_pkg::REG_A, cpu_pkg::REG_X);
    endcase
  end

endmodule

/* design/bus_sequencer.sv */
`timescale 1ns/10ps

module bus_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::byte_t       rd_data,
  input  cpu_pkg::instr_info_t info,
  input  cpu_pkg::arch_state_t arch,
  output cpu_pkg::byte_t       opcode,
  output cpu_pkg::addr_t       rd_addr,
  output cpu_pkg::commit_t     commit
);

  // Three cycles per read, then one execute cycle
  typedef enum logic [1:0] {
    S_REQ,
    S_WAIT,
    S_RECV,
    S_EXEC
  } phase_t;

  // Which byte the current read brings in
  typedef enum logic [1:0] {
    FETCH_OPCODE,
    FETCH_LO,
    FETCH_HI,
    FETCH_DATA
  } stage_t;

  phase_t         phase;
  stage_t         stage;
  cpu_pkg::byte_t opcode_q;
  cpu_pkg::byte_t oper_lo;
  cpu_pkg::byte_t oper_hi;
  cpu_pkg::byte_t data_q;     // Loaded value, immediate or from memory
  cpu_pkg::byte_t idx_val;
  cpu_pkg::pc_t   oper_word;
  cpu_pkg::pc_t   eff_addr;
  cpu_pkg::pc_t   next_pc;
  logic           opcode_rx;

  // Decode the opcode byte in the cycle it arrives
  assign opcode_rx = (phase == S_RECV) && (stage == FETCH_OPCODE);
  assign opcode    = opcode_rx ? rd_data : opcode_q;

  assign idx_val = (info.idx == cpu_pkg::REG_Y) ? arch.y : arch.x;

  // Operand as it stands when its last byte is on rd_data
  assign oper_word = (stage == FETCH_LO) ? {8'h00, rd_data} : {rd_data, oper_lo};

  always_comb begin
    case (info.mode)
      cpu_pkg::ZP_IDX:  eff_addr = {8'h00, oper_word[7:0] + idx_val};  // Page zero wrap
      cpu_pkg::ABS_IDX: eff_addr = oper_word + {8'h00, idx_val};
      default:          eff_addr = oper_word;
    endcase
  end

  assign next_pc = (info.cls == cpu_pkg::JUMP) ? {oper_hi, oper_lo}
                                               : arch.pc + cpu_pkg::pc_t'(info.len);

  always_comb begin
    commit.valid   = (phase == S_EXEC);
    commit.load    = (info.cls == cpu_pkg::LOAD);
    commit.dst     = info.dst;
    commit.value   = data_q;
    commit.next_pc = next_pc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= S_REQ;
      stage    <= FETCH_OPCODE;
      opcode_q <= 8'h00;
      rd_addr  <= cpu_pkg::addr_t'(cpu_pkg::RESET_PC);
    end else begin
      case (phase)
        S_REQ:  phase <= S_WAIT;
        S_WAIT: phase <= S_RECV;
        S_RECV: begin
          phase <= S_REQ;  // Another read unless the bytes are all in
          case (stage)
            FETCH_OPCODE: begin
              opcode_q <= rd_data;
              if (info.cls == cpu_pkg::NOP) begin
                phase <= S_EXEC;
              end else begin
                stage   <= FETCH_LO;
                rd_addr <= cpu_pkg::addr_t'(arch.pc + 16'd1);
              end
            end
            FETCH_LO: begin
              if (info.len == 2'd3) begin
                stage   <= FETCH_HI;
                rd_addr <= cpu_pkg::addr_t'(arch.pc + 16'd2);
              end else if (info.mode == cpu_pkg::IMM) begin
                phase <= S_EXEC;
              end else begin
                stage   <= FETCH_DATA;
                rd_addr <= cpu_pkg::addr_t'(eff_addr);
              end
            end
            FETCH_HI: begin
              if (info.cls == cpu_pkg::JUMP) begin
                phase <= S_EXEC;
              end else begin
                stage   <= FETCH_DATA;
                rd_addr <= cpu_pkg::addr_t'(eff_addr);
              end
            end
            default: phase <= S_EXEC;  // Data byte in
          endcase
        end
        default: begin
          // Execute, then fetch from the committed PC
          phase   <= S_REQ;
          stage   <= FETCH_OPCODE;
          rd_addr <= cpu_pkg::addr_t'(next_pc);
        end
      endcase
    end
  end

  // Operand and data capture
  always_ff @(posedge clk) begin
    if (phase == S_RECV) begin
      case (stage)
        FETCH_LO: begin
          oper_lo <= rd_data;
          data_q  <= rd_data;  // Immediate value
        end
        FETCH_HI:   oper_hi <= rd_data;
        FETCH_DATA: data_q  <= rd_data;
        default: ;
      endcase
    end
  end

endmodule

/* design/arch_regs.sv */
`timescale 1ns/10ps

module arch_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::commit_t     commit,
  output cpu_pkg::arch_state_t arch,
  output logic                 retire
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arch.pc <= cpu_pkg::RESET_PC;
      arch.a  <= 8'h00;
      arch.x  <= 8'h00;
      arch.y  <= 8'h00;
      arch.n  <= 1'b0;
      arch.z  <= 1'b0;
      retire  <= 1'b0;
    end else begin
      retire <= commit.valid;  // Lines up with the new state
      if (commit.valid) begin
        arch.pc <= commit.next_pc;
        // Flags only move on loads
        if (commit.load) begin
          case (commit.dst)
            cpu_pkg::REG_X: arch.x <= commit.value;
            cpu_pkg::REG_Y: arch.y <= commit.value;
            default:        arch.a <= commit.value;
          endcase
          arch.n <= commit.value[7];
          arch.z <= (commit.value == 8'h00);
        end
      end
    end
  end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::byte_t       rd_data,
  output cpu_pkg::addr_t       rd_addr,
  output logic                 retire,
  output cpu_pkg::arch_state_t arch
);

  cpu_pkg::byte_t       opcode;  // Byte under decode
  cpu_pkg::instr_info_t info;
  cpu_pkg::commit_t     commit;

  instr_decoder u_dec (
    .opcode (opcode),
    .info   (info)
  );

  // Fetch and execute sequencing
  bus_sequencer u_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_data (rd_data),
    .info    (info),
    .arch    (arch),
    .opcode  (opcode),
    .rd_addr (rd_addr),
    .commit  (commit)
  );

  arch_regs u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .commit (commit),
    .arch   (arch),
    .retire (retire)
  );

endmodule

/* sim/ram_model.sv */
`timescale 1ns/10ps

module ram_model (
  input  logic           clk,
  input  cpu_pkg::addr_t addr,
  output cpu_pkg::byte_t data
);

  // 8 KiB image, filled by the testbench
  cpu_pkg::byte_t mem [0:8191];

  // Address sampled on the edge, byte valid right after it
  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

/* sim/cpu_assertions.sv */
`timescale 1ns/10ps

module cpu_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 retire,
  input cpu_pkg::addr_t       rd_addr,
  input cpu_pkg::arch_state_t arch
);

  logic [4:0]     since_addr;  // Cycles since rd_addr last moved
  cpu_pkg::addr_t prev_addr;   // rd_addr one cycle back
  int             failures = 0;

  always_ff @(posedge clk) begin
    prev_addr <= rd_addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      since_addr <= 5'd0;
    end else if (rd_addr != prev_addr) begin
      since_addr <= 5'd0;
    end else if (since_addr != 5'd31) begin
      since_addr <= since_addr + 5'd1;
    end
  end

  retire_single: assert property (@(posedge clk) disable iff (!rst_n) retire |=> !retire)
    else begin
      failures++;
      $error("retire high on two consecutive cycles");
    end

  retire_in_reset: assert property (@(posedge clk) !rst_n |-> !retire)
    else begin
      failures++;
      $error("retire high during reset");
    end

  // PC only moves together with a retire
  pc_on_retire: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(arch.pc) |-> retire)
    else begin
      failures++;
      $error("arch.pc changed without retire");
    end

  addr_before_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> since_addr <= 5'd13)
    else begin
      failures++;
      $error("retire without a recent rd_addr change");
    end

endmodule

bind cpu_top cpu_assertions u_asrt (
  .clk     (clk),
  .rst_n   (rst_n),
  .retire  (retire),
  .rd_addr (rd_addr),
  .arch    (arch)
);

/* sim/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

  logic                 clk;
  logic                 rst_n;
  cpu_pkg::byte_t       rd_data;
  cpu_pkg::addr_t       rd_addr;
  logic                 retire;
  cpu_pkg::arch_state_t arch;

  cpu_pkg::byte_t       img [0:8191];  // Reference copy of RAM
  cpu_pkg::opcode_t     load_ops [0:16];
  cpu_pkg::byte_t       nop_ops [0:2];
  cpu_pkg::arch_state_t model;
  cpu_pkg::pc_t         cursor;       // Assembly address
  int cyc;
  int last_retire;
  int retire_count;
  int errors;
  int tests_run;
  int tests_failed;
  int limit;
  bit seen_first;
  int seed_val;

  cpu_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_data (rd_data),
    .rd_addr (rd_addr),
    .retire  (retire),
    .arch    (arch)
  );

  ram_model ram0 (
    .clk  (clk),
    .addr (rd_addr),
    .data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic cpu_pkg::arch_state_t reset_state();
    cpu_pkg::arch_state_t s;
    s = '0;
    s.pc = 16'h0200;
    return s;
  endfunction

  // Expected state after the instruction at s.pc, and its retire interval
  function automatic cpu_pkg::arch_state_t next_state(input cpu_pkg::arch_state_t s,
                                                      output int cycles);
    cpu_pkg::arch_state_t r;
    cpu_pkg::byte_t op;
    cpu_pkg::byte_t lo;
    cpu_pkg::byte_t hi;
    cpu_pkg::byte_t val;
    cpu_pkg::byte_t idx;
    logic [15:0] ea;
    int kind;  // 0 nop, 1 imm, 2 zp, 3 zp idx, 4 abs, 5 abs idx, 6 jmp
    int dst;   // 0 A, 1 X, 2 Y
    r = s;
    op = img[cpu_pkg::addr_t'(s.pc)];
    lo = img[cpu_pkg::addr_t'(s.pc + 16'd1)];
    hi = img[cpu_pkg::addr_t'(s.pc + 16'd2)];
    kind = 0;
    dst = 0;
    idx = s.x;
    case (op)
      cpu_pkg::JMP_ABS:  kind = 6;
      cpu_pkg::LDA_IMM:  kind = 1;
      cpu_pkg::LDA_ZP:   kind = 2;
      cpu_pkg::LDA_ZPX:  kind = 3;
      cpu_pkg::LDA_ABS:  kind = 4;
      cpu_pkg::LDA_ABSX: kind = 5;
      cpu_pkg::LDA_ABSY: begin kind = 5; idx = s.y; end
      cpu_pkg::LDX_IMM:  begin kind = 1; dst = 1; end
      cpu_pkg::LDX_ZP:   begin kind = 2; dst = 1; end
      cpu_pkg::LDX_ZPY:  begin kind = 3; dst = 1; idx = s.y; end
      cpu_pkg::LDX_ABS:  begin kind = 4; dst = 1; end
      cpu_pkg::LDX_ABSY: begin kind = 5; dst = 1; idx = s.y; end
      cpu_pkg::LDY_IMM:  begin kind = 1; dst = 2; end
      cpu_pkg::LDY_ZP:   begin kind = 2; dst = 2; end
      cpu_pkg::LDY_ZPX:  begin kind = 3; dst = 2; end
      cpu_pkg::LDY_ABS:  begin kind = 4; dst = 2; end
      cpu_pkg::LDY_ABSX: begin kind = 5; dst = 2; end
      default:           kind = 0;
    endcase
    case (kind)
      0: begin r.pc = s.pc + 16'd1; cycles = 4; return r; end
      6: begin r.pc = {hi, lo}; cycles = 10; return r; end
      1: begin val = lo; r.pc = s.pc + 16'd2; cycles = 7; end
      2: begin ea = {8'h00, lo}; r.pc = s.pc + 16'd2; cycles = 10; end
      3: begin ea = {8'h00, 8'(lo + idx)}; r.pc = s.pc + 16'd2; cycles = 10; end
      4: begin ea = {hi, lo}; r.pc = s.pc + 16'd3; cycles = 13; end
      default: begin ea = {hi, lo} + {8'h00, idx}; r.pc = s.pc + 16'd3; cycles = 13; end
    endcase
    if (kind != 1) val = img[cpu_pkg::addr_t'(ea)];
    if (dst == 0) r.a = val;
    else if (dst == 1) r.x = val;
    else r.y = val;
    r.n = val[7];
    r.z = (val == 8'h00);
    return r;
  endfunction

  task automatic check_state(input cpu_pkg::arch_state_t got, input cpu_pkg::arch_state_t exp);
    if (got.pc !== exp.pc) begin
      $display("FAIL %0t arch.pc got %h expected %h", $time, got.pc, exp.pc);
      errors++;
    end
    if (got.a !== exp.a) begin
      $display("FAIL %0t arch.a got %h expected %h", $time, got.a, exp.a);
      errors++;
    end
    if (got.x !== exp.x) begin
      $display("FAIL %0t arch.x got %h expected %h", $time, got.x, exp.x);
      errors++;
    end
    if (got.y !== exp.y) begin
      $display("FAIL %0t arch.y got %h expected %h", $time, got.y, exp.y);
      errors++;
    end
    if (got.n !== exp.n) begin
      $display("FAIL %0t arch.n got %b expected %b", $time, got.n, exp.n);
      errors++;
    end
    if (got.z !== exp.z) begin
      $display("FAIL %0t arch.z got %b expected %b", $time, got.z, exp.z);
      errors++;
    end
  endtask

  task automatic check_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t rd_addr got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_cycles(input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %0t retire interval got %0d expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  // Comparison on every retire, plus the run limit
  always @(posedge clk) begin
    int exp_cycles;
    cpu_pkg::arch_state_t exp;
    cyc++;
    if (cyc > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped retiring instructions", cyc);
      $display("Finished with errors");
      $finish;
    end else if (!rst_n) begin
      model = reset_state();
      seen_first = 1'b0;
    end else if (retire) begin
      exp = next_state(model, exp_cycles);
      check_state(arch, exp);
      if (seen_first) check_cycles(cyc - last_retire, exp_cycles);
      seen_first = 1'b1;
      last_retire = cyc;
      model = exp;
      retire_count++;
    end
  end

  task automatic put_instr(input cpu_pkg::byte_t op, input int nbytes, input logic [15:0] w);
    img[cpu_pkg::addr_t'(cursor)] = op;
    if (nbytes > 1) img[cpu_pkg::addr_t'(cursor + 16'd1)] = w[7:0];
    if (nbytes > 2) img[cpu_pkg::addr_t'(cursor + 16'd2)] = w[15:8];
    cursor = cursor + 16'(nbytes);
  endtask

  task automatic load_ram();
    for (int a = 0; a < 8192; a++) ram0.mem[a] = img[a];
  endtask

  task automatic run_test(input string name, input int n);
    int start_err;
    int target;
    start_err = errors;
    target = retire_count + n;
    wait (retire_count >= target);
    tests_run++;
    if (errors == start_err) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed", name);
      tests_failed++;
    end
  endtask

  task automatic build_directed();
    for (int a = 0; a < 8192; a++) img[a] = 8'((a * 37) ^ (a >> 8));  // Whole-address fill
    img[13'h0020] = 8'h00;
    img[13'h0021] = 8'h9C;
    img[13'h0008] = 8'h41;
    img[13'h0035] = 8'hC3;
    img[13'h1234] = 8'h80;
    img[13'h13F4] = 8'h00;
    img[13'h1FFF] = 8'hF0;
    cursor = 16'h0200;
    // Immediate loads
    put_instr(cpu_pkg::LDA_IMM, 2, 16'h00);
    put_instr(cpu_pkg::LDX_IMM, 2, 16'h80);
    put_instr(cpu_pkg::LDY_IMM, 2, 16'h35);
    put_instr(cpu_pkg::LDA_IMM, 2, 16'hFF);
    put_instr(cpu_pkg::LDX_IMM, 2, 16'h7F);
    // Zero page loads with F8+10 and FA+C3 wrapping
    put_instr(cpu_pkg::LDX_IMM, 2, 16'h10);
    put_instr(cpu_pkg::LDA_ZP, 2, 16'h20);
    put_instr(cpu_pkg::LDY_ZP, 2, 16'h21);
    put_instr(cpu_pkg::LDA_ZPX, 2, 16'hF8);
    put_instr(cpu_pkg::LDY_IMM, 2, 16'h05);
    put_instr(cpu_pkg::LDX_ZPY, 2, 16'h30);
    put_instr(cpu_pkg::LDY_ZPX, 2, 16'hFA);
    // Absolute and indexed
    put_instr(cpu_pkg::LDA_ABS, 3, 16'h1234);
    put_instr(cpu_pkg::LDX_IMM, 2, 16'h04);
    put_instr(cpu_pkg::LDA_ABSX, 3, 16'h13F0);
    put_instr(cpu_pkg::LDY_IMM, 2, 16'h20);
    put_instr(cpu_pkg::LDA_ABSY, 3, 16'h1300);
    put_instr(cpu_pkg::LDX_ABSY, 3, 16'h1400);
    put_instr(cpu_pkg::LDY_ABSX, 3, 16'h15FE);
    put_instr(cpu_pkg::LDX_ABS, 3, 16'h1111);
    put_instr(cpu_pkg::LDY_ABS, 3, 16'h1FFF);
    put_instr(cpu_pkg::LDA_IMM, 2, 16'h01);
    // No-ops around a jump to a second block
    put_instr(8'hEA, 1, 16'h0);
    put_instr(8'h02, 1, 16'h0);
    put_instr(cpu_pkg::LDA_IMM, 2, 16'h00);
    put_instr(8'h1A, 1, 16'h0);
    put_instr(cpu_pkg::JMP_ABS, 3, 16'h0400);
    cursor = 16'h0400;
    put_instr(cpu_pkg::LDX_IMM, 2, 16'h55);
    put_instr(8'hEA, 1, 16'h0);
    put_instr(cpu_pkg::JMP_ABS, 3, 16'h0400);
  endtask

  task automatic build_random(input int n);
    cpu_pkg::arch_state_t s;
    int r;
    int cy;
    for (int a = 0; a < 8192; a++) img[a] = 8'($urandom);
    cursor = 16'h0200;
    s = reset_state();
    for (int i = 0; i < n; i++) begin
      r = $urandom % 20;
      img[cpu_pkg::addr_t'(cursor)] = (r < 17) ? load_ops[r] : nop_ops[r - 17];
      img[cpu_pkg::addr_t'(cursor + 16'd1)] = 8'($urandom);
      img[cpu_pkg::addr_t'(cursor + 16'd2)] = 8'($urandom);
      s.pc = cursor;
      s = next_state(s, cy);  // Only the length matters here
      cursor = s.pc;
    end
    put_instr(cpu_pkg::JMP_ABS, 3, cursor);
  endtask

  initial begin
    rst_n = 1'b0;
    cyc = 0;
    last_retire = 0;
    retire_count = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    seen_first = 1'b0;
    model = reset_state();
    limit = 2 * 13 * (30 + 81) + 2 * 4;  // 111 instructions, two resets
    seed_val = 89965;
    seed_val = $urandom(seed_val);  // Seeds the generator for the whole run
    load_ops = '{cpu_pkg::LDA_IMM, cpu_pkg::LDA_ZP, cpu_pkg::LDA_ZPX, cpu_pkg::LDA_ABS,
                 cpu_pkg::LDA_ABSX, cpu_pkg::LDA_ABSY, cpu_pkg::LDX_IMM, cpu_pkg::LDX_ZP,
                 cpu_pkg::LDX_ZPY, cpu_pkg::LDX_ABS, cpu_pkg::LDX_ABSY, cpu_pkg::LDY_IMM,
                 cpu_pkg::LDY_ZP, cpu_pkg::LDY_ZPX, cpu_pkg::LDY_ABS, cpu_pkg::LDY_ABSX,
                 cpu_pkg::LDA_IMM};
    nop_ops = '{8'hEA, 8'h1A, 8'h02};
    build_directed();
    load_ram();

    begin
      int start_err;
      start_err = errors;
      // Sampled between the reset edges
      repeat (3) begin
        @(negedge clk);
        check_state(arch, reset_state());
        check_addr(rd_addr, 13'h0200);
        if (retire !== 1'b0) begin
          $display("Retire went high while reset was asserted");
          errors++;
        end
      end
      @(posedge clk);
      rst_n <= 1'b1;
      tests_run++;
      if (errors == start_err) begin
        $display("Test reset values: passed");
      end else begin
        $display("Test reset values: failed");
        tests_failed++;
      end
    end

    run_test("immediate loads", 5);
    run_test("zero page loads", 7);
    run_test("absolute loads", 10);
    run_test("jump and no-ops", 8);

    // Second run from reset with a random program
    @(posedge clk);
    rst_n <= 1'b0;
    build_random(80);
    load_ram();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    run_test("random program", 81);

    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, dut0.u_asrt.failures);
    if (errors == 0 && dut0.u_asrt.failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/cpu_pkg.sv
design/instr_decoder.sv
design/bus_sequencer.sv
design/arch_regs.sv
design/cpu_top.sv
sim/ram_model.sv
sim/cpu_assertions.sv
sim/tb_cpu.sv
